//--- src.f
+incdir+.
votrax_pkg.sv
votrax_rom.sv
votrax_timing.sv
votrax_phone_ctrl.sv
votrax_interp.sv
votrax_noise.sv
votrax_sc01a.sv
tb_votrax_sc01a.sv

//--- tb_votrax_checks.svh
/*
 * Compare tasks for the SC01A testbench, typed to the DUT's
 * parameter vector, single-bit outputs and phone durations
 */
`ifndef TB_VOTRAX_CHECKS_SVH
`define TB_VOTRAX_CHECKS_SVH

// Single-bit outputs such as noise_out and phone_ack
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        abort_run("single-bit output mismatch");
    end
endtask

// Whole parameter vector, field by field in ROM slot order
task automatic check_params(input string name, input param_vec_t got,
                            input param_vec_t exp);
    param_t [NUM_PARAMS-1:0] g;
    param_t [NUM_PARAMS-1:0] e;
    param_sel_e              sel;
    g = got;
    e = exp;
    for (int i = 0; i < NUM_PARAMS; i++) begin
        if (g[i] !== e[i]) begin
            sel = param_sel_e'(NUM_PARAMS - 1 - i);
            $display("** Error at %0t: %s.%s = %0d, expected %0d", $time, name,
                     sel.name(), g[i], e[i]);
            abort_run("parameter vector mismatch");
        end
    end
endtask

// Phone length in clk cycles against its allowed window
task automatic check_duration(input string name, input int cycles,
                              input int lo, input int hi);
    if (cycles < lo || cycles > hi) begin
        $display("** Error at %0t: %s = %0d cycles, expected %0d..%0d",
                 $time, name, cycles, lo, hi);
        abort_run("phone duration out of range");
    end
endtask

`endif

//--- tb_votrax_sc01a.sv
/*
 * Testbench for the SC01A core: noise sequence after reset,
 * phone handshake and back-pressure, durations, interpolation
 * and pause behavior, driven from the stimulus file
 */
`timescale 1ns/10ps
`default_nettype none

module tb_votrax_sc01a import votrax_pkg::*; ();

    logic       clk = 1'b0;
    logic       reset_n;
    phone_t     phone_in;
    logic       phone_req;
    logic       phone_ack;
    logic       busy;
    param_vec_t params;
    logic       noise_out;

    // Stimulus table
    phone_t     st_phone[$];
    int         st_dur[$];
    param_vec_t st_tgt[$];

    int         cycle;
    int         ack_cycle;
    int         seed = 51;
    param_vec_t cur_tgt;
    logic       pause_active;
    logic       noise_hold;
    logic [NOISE_WIDTH-1:0]  noise_model;
    param_t [NUM_PARAMS-1:0] now_v;
    param_t [NUM_PARAMS-1:0] prev_v;
    param_t [NUM_PARAMS-1:0] tgt_v;
    int         last_change[NUM_PARAMS];

    votrax_sc01a UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .phone_in  (phone_in),
        .phone_req (phone_req),
        .phone_ack (phone_ack),
        .busy      (busy),
        .params    (params),
        .noise_out (noise_out)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    `include "tb_votrax_checks.svh"

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // ============================================================
    // Interpolation and pause monitor
    // ============================================================
    always @(negedge clk) begin
        if (reset_n) begin
            now_v = params;
            tgt_v = cur_tgt;
            for (int i = 0; i < NUM_PARAMS; i++) begin
                if (now_v[i] !== prev_v[i]) begin
                    if ((int'(now_v[i]) > int'(prev_v[i]) + 1) ||
                        (int'(prev_v[i]) > int'(now_v[i]) + 1) ||
                        (now_v[i] > prev_v[i] && prev_v[i] >= tgt_v[i]) ||
                        (now_v[i] < prev_v[i] && prev_v[i] <= tgt_v[i]) ||
                        (cycle - last_change[i] < TICK_DIV)) begin
                        $display("** Error at %0t: params[%0d] = %0d, expected step %0d->%0d",
                                 $time, i, now_v[i], prev_v[i], tgt_v[i]);
                        abort_run("illegal parameter step");
                    end
                    last_change[i] = cycle;
                end
            end
            prev_v = now_v;
            if (!busy) begin
                pause_active = 1'b0;
            end else if (pause_active) begin
                check_bit("noise_out", noise_out, noise_hold);
            end
        end
    end

    // ============================================================
    // Phone tasks
    // ============================================================
    // Raise the request, wait for the acknowledge
    task automatic request_phone(input int idx, input bit queued);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        phone_in  <= st_phone[idx];
        phone_req <= 1'b1;
        @(negedge clk);
        while (queued && busy) begin
            check_bit("phone_ack", phone_ack, 1'b0);
            wait_cnt++;
            if (wait_cnt > 5000) abort_run("timeout waiting for busy to fall before latch");
            @(negedge clk);
        end
        check_bit("phone_ack", phone_ack, 1'b0);
        check_bit("busy", busy, 1'b0);
        @(negedge clk);
        check_bit("phone_ack", phone_ack, 1'b1);
        check_bit("busy", busy, 1'b1);
        ack_cycle = cycle;
        cur_tgt   = st_tgt[idx];
        if (st_phone[idx] == PAUSE_PHONE_A || st_phone[idx] == PAUSE_PHONE_B) begin
            noise_hold   = noise_out;
            pause_active = 1'b1;
        end
    endtask

    // Drop the request, acknowledge follows one cycle later
    task automatic release_req();
        @(posedge clk);
        phone_req <= 1'b0;
        @(negedge clk);
        check_bit("phone_ack", phone_ack, 1'b1);
        @(negedge clk);
        check_bit("phone_ack", phone_ack, 1'b0);
    endtask

    task automatic finish_phone(input int idx);
        int wait_cnt;
        wait_cnt = 0;
        while (busy) begin
            wait_cnt++;
            if (wait_cnt > 5000) abort_run("timeout waiting for the phone to end");
            @(negedge clk);
        end
        check_duration("phone length", cycle - ack_cycle, st_dur[idx] * 32,
                       (st_dur[idx] + 1) * 32 + 1);
        if (st_dur[idx] >= 4) check_params("params", params, st_tgt[idx]);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int    fd;
        int    n;
        int    v[9];
        int    idx;
        string line;
        reset_n   <= 1'b0;
        phone_in  <= '0;
        phone_req <= 1'b0;
        cur_tgt      = '0;
        prev_v       = '0;
        pause_active = 1'b0;
        noise_hold   = 1'b0;
        noise_model  = '0;
        for (int i = 0; i < NUM_PARAMS; i++) last_change[i] = -TICK_DIV;

        fd = $fopen("votrax_stim.txt", "r");
        if (fd == 0) abort_run("cannot open votrax_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %d %d %d %d %d %d %d %d",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (n == 9) begin
                    st_phone.push_back(phone_t'(v[0]));
                    st_dur.push_back(v[1]);
                    st_tgt.push_back({param_t'(v[2]), param_t'(v[3]), param_t'(v[4]),
                                      param_t'(v[5]), param_t'(v[6]), param_t'(v[7]),
                                      param_t'(v[8])});
                end
            end
        end
        $fclose(fd);
        if (st_phone.size() < 4) abort_run("too few phones in votrax_stim.txt");

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // Free-running noise, one shift per 8 cycles
        for (int k = 1; k <= 600; k++) begin
            @(posedge clk);
            if (k % TICK_DIV == 0) begin
                noise_model = {noise_model[NOISE_WIDTH-2:0],
                               ~(noise_model[NOISE_TAP_A] ^ noise_model[NOISE_TAP_B])};
            end
            @(negedge clk);
            check_bit("noise_out", noise_out,
                      noise_model[NOISE_TAP_A] ^ noise_model[NOISE_TAP_B]);
        end

        for (int i = 0; i < st_phone.size(); i++) begin
            request_phone(i, 1'b0);
            release_req();
            finish_phone(i);
        end

        // Second request held off while the first phone plays
        request_phone(1, 1'b0);
        release_req();
        request_phone(2, 1'b1);
        release_req();
        finish_phone(2);

        for (int r = 0; r < 3; r++) begin
            idx = $unsigned($random(seed)) % st_phone.size();
            request_phone(idx, 1'b0);
            release_req();
            finish_phone(idx);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- votrax_interp.sv
/*
 * Interpolator: seven 4-bit parameter registers, each stepping
 * by one toward its ROM target on every parameter tick
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_interp import votrax_pkg::*; (
    input  wire             clk,
    input  wire             reset_n,
    input  wire tick_t      ticks,
    input  wire             busy,
    input  wire             pause,
    input  wire param_vec_t targets,
    output param_vec_t      params
);

    // Array views of the parameter vectors
    param_t [NUM_PARAMS-1:0] cur_vec;
    param_t [NUM_PARAMS-1:0] tgt_vec;
    param_t [NUM_PARAMS-1:0] nxt_vec;

    assign cur_vec = params;

    // Pause phones fade everything out
    assign tgt_vec = pause ? '0 : targets;

    // ============================================================
    // Step toward target
    // ============================================================
    always_comb begin
        for (int i = 0; i < NUM_PARAMS; i++) begin
            if (cur_vec[i] < tgt_vec[i]) begin
                nxt_vec[i] = cur_vec[i] + 4'd1;
            end else if (cur_vec[i] > tgt_vec[i]) begin
                nxt_vec[i] = cur_vec[i] - 4'd1;
            end else begin
                nxt_vec[i] = cur_vec[i];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            params <= '0;
        end else if (ticks.param_tick && busy) begin
            params <= nxt_vec;
        end
    end

    // Each field moves at most one step per cycle
    for (genvar g = 0; g < NUM_PARAMS; g++) begin : g_step_chk
        a_one_step: assert property (@(posedge clk) disable iff (!reset_n)
            (5'(cur_vec[g]) <= 5'($past(cur_vec[g])) + 5'd1) &&
            (5'($past(cur_vec[g])) <= 5'(cur_vec[g]) + 5'd1));
    end

endmodule

`default_nettype wire

//--- votrax_noise.sv
/*
 * Noise source: 30-bit shift register with XNOR feedback,
 * frozen while a pause phone plays
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_noise import votrax_pkg::*; (
    input  wire   clk,
    input  wire   reset_n,
    input  wire   tick_t ticks,
    input  wire   busy,
    input  wire   pause,
    output logic  noise_out
);

    logic [NOISE_WIDTH-1:0] noise_q;
    logic                   tap_xor;

    assign tap_xor   = noise_q[NOISE_TAP_A] ^ noise_q[NOISE_TAP_B];
    assign noise_out = tap_xor;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            noise_q <= '0;
        end else if (ticks.param_tick && !(busy && pause)) begin
            noise_q <= {noise_q[NOISE_WIDTH-2:0], ~tap_xor};
        end
    end

    // All ones would lock the XNOR feedback
    a_no_lockup: assert property (@(posedge clk) disable iff (!reset_n) !(&noise_q));

endmodule

`default_nettype wire

//--- votrax_phone_ctrl.sv
/*
 * Phone controller: four-phase req/ack handshake, phone latch,
 * pause detect and the phone duration counter
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_phone_ctrl import votrax_pkg::*; (
    input  wire         clk,
    input  wire         reset_n,
    input  wire tick_t  ticks,
    input  wire phone_t phone_in,
    input  wire         phone_req,
    input  wire [6:0]   duration,
    output logic        phone_ack,
    output logic        busy,
    output phone_t      phone,
    output logic        pause
);

    phone_state_e state;
    logic [6:0]   dur_cnt;
    logic         dur_loaded;
    logic         phone_done;
    logic         latch;

    // New phone only accepted from idle
    assign latch = (state == IDLE) && phone_req;

    // Last phone tick of the current phone
    assign phone_done = busy && ticks.phone_tick &&
                        (dur_loaded ? (dur_cnt == 7'd1) : (duration == 7'd0));

    // ============================================================
    // Handshake FSM
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            phone_ack <= 1'b0;
            phone     <= '0;
            pause     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (phone_req) begin
                        state     <= ACK;
                        phone_ack <= 1'b1;
                        phone     <= phone_in;
                        pause     <= (phone_in == PAUSE_PHONE_A) ||
                                     (phone_in == PAUSE_PHONE_B);
                    end
                end
                ACK: begin
                    // Host released the request
                    if (!phone_req) begin
                        phone_ack <= 1'b0;
                        state     <= (busy && !phone_done) ? PLAY : IDLE;
                    end
                end
                PLAY: begin
                    if (phone_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ============================================================
    // Duration counter
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            dur_cnt    <= '0;
            dur_loaded <= 1'b0;
        end else if (latch) begin
            busy       <= 1'b1;
            dur_loaded <= 1'b0;
        end else if (phone_done) begin
            busy <= 1'b0;
        end else if (busy && ticks.phone_tick) begin
            // First tick after the latch takes the ROM duration
            if (!dur_loaded) begin
                dur_cnt    <= duration;
                dur_loaded <= 1'b1;
            end else begin
                dur_cnt <= dur_cnt - 7'd1;
            end
        end
    end

    // No acknowledge while a phone is still playing
    a_no_ack_in_play: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(phone_ack) |-> $past(!busy && state != PLAY));

endmodule

`default_nettype wire

//--- votrax_pkg.sv
/*
 * Shared definitions for the SC01A core: phone and parameter words,
 * parameter vector and ROM entry structs, clock-enable bundle,
 * phone controller states and fixed timing constants
 */
`default_nettype none

package votrax_pkg;

    // ============================================================
    // Basic words
    // ============================================================
    typedef logic [5:0] phone_t;
    typedef logic [3:0] param_t;

    // Slot order of the seven parameters in the phone ROM
    typedef enum logic [2:0] {
        F1  = 3'd0,
        VA  = 3'd1,
        F2  = 3'd2,
        FC  = 3'd3,
        F2Q = 3'd4,
        F3  = 3'd5,
        FA  = 3'd6
    } param_sel_e;

    typedef struct packed {
        param_t f1;
        param_t va;
        param_t f2;
        param_t fc;
        param_t f2q;
        param_t f3;
        param_t fa;
    } param_vec_t;

    typedef struct packed {
        logic [6:0] duration;
        param_vec_t targets;
    } rom_entry_t;

    // Single-cycle enables from the tick generator
    typedef struct packed {
        logic param_tick;
        logic phone_tick;
    } tick_t;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        PLAY
    } phone_state_e;

    // ============================================================
    // Constants
    // ============================================================
    localparam int TICK_DIV    = 8;    // clk cycles per parameter tick
    localparam int PHONE_DIV   = 4;    // parameter ticks per phone tick
    localparam int NOISE_WIDTH = 30;
    localparam int NOISE_TAP_A = 29;
    localparam int NOISE_TAP_B = 27;
    localparam int NUM_PARAMS  = 7;

    // Silent phones
    localparam phone_t PAUSE_PHONE_A = 6'h03;
    localparam phone_t PAUSE_PHONE_B = 6'h3e;

endpackage

`default_nettype wire

//--- votrax_rom.sv
/*
 * Phone ROM: 64-entry table of two data words per phone, and the
 * decode of one entry into a duration and seven parameter targets
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_rom import votrax_pkg::*; (
    input  wire phone_t phone,
    output rom_entry_t  entry
);

    // Upper 12 bits hold word 0, lower 32 bits word 1
    logic [43:0] rom_word;
    logic [6:0]  dur_field;
    logic [31:0] param_word;

    // Four scattered bits per parameter, slot index selects the lane
    function automatic param_t get_param(logic [31:0] word, param_sel_e sel);
        logic [31:0] base;
        base = word >> sel;
        return {base[0], base[7], base[14], base[21]};
    endfunction

    // ============================================================
    // Table
    // ============================================================
    always_comb begin
        case (phone)
            6'h00: rom_word = {12'h361, 32'h74688127};
            6'h01: rom_word = {12'h161, 32'hd4688127};
            6'h02: rom_word = {12'h9a1, 32'hc4688127};
            6'h03: rom_word = {12'h0e0, 32'hf0a050a4};
            6'h04: rom_word = {12'h0fb, 32'h610316e8};
            6'h05: rom_word = {12'h161, 32'h64c9c1a6};
            6'h06: rom_word = {12'h7a1, 32'h34c9c1a6};
            6'h07: rom_word = {12'h463, 32'hf3cb546c};
            6'h08: rom_word = {12'h161, 32'hc4e940a3};
            6'h09: rom_word = {12'hb61, 32'h806191a6};
            6'h0a: rom_word = {12'ha61, 32'h906191a6};
            6'h0b: rom_word = {12'h9a1, 32'h906191a6};
            6'h0c: rom_word = {12'h7a3, 32'h66a58832};
            6'h0d: rom_word = {12'ha61, 32'he6241936};
            6'h0e: rom_word = {12'h173, 32'h90e19122};
            6'h0f: rom_word = {12'h163, 32'hf7d36428};
            6'h10: rom_word = {12'h163, 32'hfb8b546c};
            6'h11: rom_word = {12'h9a2, 32'hfb8b546c};
            6'h12: rom_word = {12'h163, 32'h9cd15860};
            6'h13: rom_word = {12'h8a0, 32'h706980a3};
            6'h14: rom_word = {12'h9a0, 32'hd4084b36};
            6'h15: rom_word = {12'h8a1, 32'h84e940a3};
            6'h16: rom_word = {12'h7a1, 32'h30498123};
            6'h17: rom_word = {12'ha21, 32'h20498123};
            6'h18: rom_word = {12'h7a1, 32'hf409d0a2};
            6'h19: rom_word = {12'ha72, 32'h1123642c};
            6'h1a: rom_word = {12'h0e8, 32'hdb7b342c};
            6'h1b: rom_word = {12'h162, 32'hfd2204ac};
            6'h1c: rom_word = {12'h173, 32'he041c126};
            6'h1d: rom_word = {12'h7a2, 32'h65832ca8};
            6'h1e: rom_word = {12'hb7c, 32'h00e89126};
            6'h1f: rom_word = {12'h468, 32'h489132e0};
            6'h20: rom_word = {12'ha21, 32'h84c9c1a6};
            6'h21: rom_word = {12'h561, 32'h7069d326};
            6'h22: rom_word = {12'ha61, 32'h64a01226};
            6'h23: rom_word = {12'h0e3, 32'h548981a3};
            6'h24: rom_word = {12'hcc1, 32'h84e940a3};
            6'h25: rom_word = {12'h7b2, 32'h631324a8};
            6'h26: rom_word = {12'ha21, 32'h84e8c1a2};
            6'h27: rom_word = {12'ha21, 32'h806191a6};
            6'h28: rom_word = {12'ha21, 32'h80e8c122};
            6'h29: rom_word = {12'h7a1, 32'h64015326};
            6'h2a: rom_word = {12'h172, 32'he81132e0};
            6'h2b: rom_word = {12'h463, 32'h54084382};
            6'h2c: rom_word = {12'ha20, 32'h7049d326};
            6'h2d: rom_word = {12'ha66, 32'h1460c122};
            6'h2e: rom_word = {12'ha20, 32'h74e880a7};
            6'h2f: rom_word = {12'h7a0, 32'h74e880a7};
            6'h30: rom_word = {12'h461, 32'h606980a3};
            6'h31: rom_word = {12'h163, 32'h548981a3};
            6'h32: rom_word = {12'h7a1, 32'he48981a3};
            6'h33: rom_word = {12'ha21, 32'hb48981a3};
            6'h34: rom_word = {12'ha61, 32'h34e8c1a2};
            6'h35: rom_word = {12'h9a1, 32'h80e8c1a2};
            6'h36: rom_word = {12'h366, 32'h106083a2};
            6'h37: rom_word = {12'h461, 32'h90e8c122};
            6'h38: rom_word = {12'ha63, 32'h88e15220};
            6'h39: rom_word = {12'h168, 32'h183800a4};
            6'h3a: rom_word = {12'h8a1, 32'h2448c382};
            6'h3b: rom_word = {12'ha21, 32'h94688127};
            6'h3c: rom_word = {12'h9a1, 32'h9049d326};
            6'h3d: rom_word = {12'hcc1, 32'hb06980a3};
            6'h3e: rom_word = {12'ha23, 32'h00a050a4};
            6'h3f: rom_word = {12'h0f0, 32'h30a058a4};
        endcase
    end

    // ============================================================
    // Entry decode
    // ============================================================
    // Duration is word 0 bits 11..5
    assign dur_field  = rom_word[43:37];
    assign param_word = rom_word[31:0];

    always_comb begin
        // Stored bit-reversed, word 0 bit 5 is the duration MSB
        for (int i = 0; i < 7; i++) begin
            entry.duration[i] = dur_field[6 - i];
        end
        entry.targets.f1  = get_param(param_word, F1);
        entry.targets.va  = get_param(param_word, VA);
        entry.targets.f2  = get_param(param_word, F2);
        entry.targets.fc  = get_param(param_word, FC);
        entry.targets.f2q = get_param(param_word, F2Q);
        entry.targets.f3  = get_param(param_word, F3);
        entry.targets.fa  = get_param(param_word, FA);
    end

endmodule

`default_nettype wire

//--- votrax_sc01a.sv
/*
 * SC01A core top level: tick generator, phone controller,
 * phone ROM, interpolator and noise source
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_sc01a import votrax_pkg::*; (
    input  wire         clk,
    input  wire         reset_n,
    input  wire phone_t phone_in,
    input  wire         phone_req,
    output logic        phone_ack,
    output logic        busy,
    output param_vec_t  params,
    output logic        noise_out
);

    tick_t      ticks;
    phone_t     phone;
    logic       pause;
    rom_entry_t entry;

    // ============================================================
    // Control path
    // ============================================================
    votrax_timing u_timing (
        .clk     (clk),
        .reset_n (reset_n),
        .ticks   (ticks)
    );

    votrax_phone_ctrl u_phone_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .ticks     (ticks),
        .phone_in  (phone_in),
        .phone_req (phone_req),
        .duration  (entry.duration),
        .phone_ack (phone_ack),
        .busy      (busy),
        .phone     (phone),
        .pause     (pause)
    );

    votrax_rom u_rom (
        .phone (phone),
        .entry (entry)
    );

    // ============================================================
    // Parameter and noise outputs
    // ============================================================
    votrax_interp u_interp (
        .clk     (clk),
        .reset_n (reset_n),
        .ticks   (ticks),
        .busy    (busy),
        .pause   (pause),
        .targets (entry.targets),
        .params  (params)
    );

    votrax_noise u_noise (
        .clk       (clk),
        .reset_n   (reset_n),
        .ticks     (ticks),
        .busy      (busy),
        .pause     (pause),
        .noise_out (noise_out)
    );

endmodule

`default_nettype wire

//--- votrax_stim.txt
# phone(hex) duration(dec) then targets f1 va f2 fc f2q f3 fa (dec)
# pause phones list zero targets, the level they fade to
00 108 9 15 8 0 0 11 0
24 51 15 9 3 0 0 11 0
03 112 0 0 0 0 0 0 0
18 94 6 10 2 0 0 15 0
3e 69 0 0 0 0 0 0 0
13 81 13 11 2 0 0 10 0

//--- votrax_timing.sv
/*
 * Tick generator: parameter tick every TICK_DIV clocks and
 * phone tick on every PHONE_DIV-th parameter tick
 */
`timescale 1ns/10ps
`default_nettype none

module votrax_timing import votrax_pkg::*; (
    input  wire   clk,
    input  wire   reset_n,
    output tick_t ticks
);

    logic [$clog2(TICK_DIV)-1:0]  div_cnt;
    logic [$clog2(PHONE_DIV)-1:0] sub_cnt;
    logic                         param_tick;

    // Last clk of each divider period
    assign param_tick = (div_cnt == TICK_DIV - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            sub_cnt <= '0;
        end else begin
            if (param_tick) begin
                div_cnt <= '0;
                // Phone time base counts parameter ticks
                if (sub_cnt == PHONE_DIV - 1) begin
                    sub_cnt <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        ticks.param_tick = param_tick;
        ticks.phone_tick = param_tick && (sub_cnt == PHONE_DIV - 1);
    end

endmodule

`default_nettype wire
